//--- design/prc_bus_pkg.sv
package prc_bus_pkg;

    // One access on the shared memory bus
    typedef struct packed {
        logic        read;
        logic        write;
        logic [23:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    // Fixed memory map
    localparam logic [23:0] VRAM_BASE        = 24'h001000;
    localparam logic [23:0] VRAM_PAGE_STRIDE = 24'd96;      // Bytes per LCD page in VRAM
    localparam logic [23:0] TILE_MAP_BASE    = 24'h001360;
    localparam logic [23:0] LCD_CMD_ADDR     = 24'h0020FE;
    localparam logic [23:0] LCD_DATA_ADDR    = 24'h0020FF;

    // LCD controller commands
    localparam logic [7:0] LCD_COL_LOW_CMD  = 8'h10;
    localparam logic [7:0] LCD_COL_HIGH_CMD = 8'h00;
    localparam logic [7:0] LCD_PAGE_CMD     = 8'hB0;        // Page number in bits 2:0

endpackage

//--- design/prc_cfg_pkg.sv
package prc_cfg_pkg;

    // CPU register write port
    typedef struct packed {
        logic        write;
        logic [23:0] addr;
        logic [7:0]  wdata;
    } cpu_bus_t;

    // Mode register, bit 0 is invert
    typedef struct packed {
        logic [1:0] map_size;
        logic       copy_en;
        logic       sprite_en;  // Stored, no sprite stage
        logic       map_en;
        logic       invert;
    } prc_mode_t;

    // What the map renderer needs from the register file
    typedef struct packed {
        logic [4:0]  map_width;   // In tiles
        logic [6:0]  scroll_x;    // Effective, already clamped
        logic [6:0]  scroll_y;
        logic [20:0] map_base;    // Tile graphics, low 3 bits zero
    } map_geom_t;

    // Register addresses
    localparam logic [23:0] REG_MODE         = 24'h002080;
    localparam logic [23:0] REG_MAP_BASE_LO  = 24'h002082;
    localparam logic [23:0] REG_MAP_BASE_MID = 24'h002083;
    localparam logic [23:0] REG_MAP_BASE_HI  = 24'h002084;
    localparam logic [23:0] REG_SCROLL_Y     = 24'h002085;
    localparam logic [23:0] REG_SCROLL_X     = 24'h002086;

endpackage

//--- design/prc_registers.sv
`timescale 1ns/1ps

module prc_registers #(
    parameter int SCREEN_COLUMNS = 96,
    parameter int SCREEN_PAGES   = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  prc_cfg_pkg::cpu_bus_t   cpu,
    input  logic [23:0]             reg_rd_addr,
    output logic [7:0]              reg_rd_data,
    output prc_cfg_pkg::prc_mode_t  mode,
    output prc_cfg_pkg::map_geom_t  geom
);
    import prc_cfg_pkg::*;

    logic [20:3]       map_base_q;
    logic [6:0]        scroll_x_raw;
    logic [6:0]        scroll_y_raw;
    logic [6:0]        scroll_x_eff;
    logic [6:0]        scroll_y_eff;
    logic [4:0]        map_width;
    logic [4:0]        map_height;
    logic signed [9:0] limit_x;
    logic signed [9:0] limit_y;

    always_comb
    begin
        case (mode.map_size)
            2'd0:    begin map_width = 5'd12; map_height = 5'd16; end
            2'd1:    begin map_width = 5'd16; map_height = 5'd12; end
            2'd2:    begin map_width = 5'd24; map_height = 5'd8;  end
            default: begin map_width = 5'd24; map_height = 5'd16; end
        endcase
    end

    // Largest scroll that keeps the screen inside the map
    assign limit_x = $signed({2'b00, map_width, 3'b000}) - $signed(10'(SCREEN_COLUMNS));
    assign limit_y = $signed({2'b00, map_height, 3'b000}) - $signed(10'(8 * SCREEN_PAGES));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mode         <= '0;
            map_base_q   <= '0;
            scroll_x_raw <= '0;
            scroll_y_raw <= '0;
            scroll_x_eff <= '0;
            scroll_y_eff <= '0;
        end
        else if (cpu.write)
        begin
            case (cpu.addr)
                REG_MODE:         mode <= cpu.wdata[5:0];
                REG_MAP_BASE_LO:  map_base_q[7:3] <= cpu.wdata[7:3];
                REG_MAP_BASE_MID: map_base_q[15:8] <= cpu.wdata;
                REG_MAP_BASE_HI:  map_base_q[20:16] <= cpu.wdata[4:0];
                REG_SCROLL_Y:
                begin
                    scroll_y_raw <= cpu.wdata[6:0];
                    if ($signed({3'b000, cpu.wdata[6:0]}) <= limit_y)
                        scroll_y_eff <= cpu.wdata[6:0];
                end
                REG_SCROLL_X:
                begin
                    scroll_x_raw <= cpu.wdata[6:0];
                    if ($signed({3'b000, cpu.wdata[6:0]}) <= limit_x)
                        scroll_x_eff <= cpu.wdata[6:0];    // Out of range keeps the old value
                end
                default: ;
            endcase
        end
    end

    always_comb
    begin
        case (reg_rd_addr)
            REG_MODE:         reg_rd_data = {2'b00, mode};
            REG_MAP_BASE_LO:  reg_rd_data = {map_base_q[7:3], 3'b000};
            REG_MAP_BASE_MID: reg_rd_data = map_base_q[15:8];
            REG_MAP_BASE_HI:  reg_rd_data = {3'b000, map_base_q[20:16]};
            REG_SCROLL_Y:     reg_rd_data = {1'b0, scroll_y_raw};
            REG_SCROLL_X:     reg_rd_data = {1'b0, scroll_x_raw};
            default:          reg_rd_data = 8'h00;
        endcase
    end

    always_comb
    begin
        geom.map_width = map_width;
        geom.scroll_x  = scroll_x_eff;
        geom.scroll_y  = scroll_y_eff;
        geom.map_base  = {map_base_q, 3'b000};
    end

endmodule

//--- design/prc_map_renderer.sv
`timescale 1ns/1ps

module prc_map_renderer #(
    parameter int SCREEN_COLUMNS = 96,
    parameter int SCREEN_PAGES   = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  prc_cfg_pkg::map_geom_t  geom,
    input  logic                    invert,
    input  logic [7:0]              mem_rd_data,
    output prc_bus_pkg::mem_req_t   mem_req,
    output logic                    done
);
    import prc_bus_pkg::*;

    logic        active;
    logic        phase;      // 0 issues an access, 1 takes the read data
    logic [2:0]  step;       // Five accesses per column
    logic [6:0]  col;
    logic [2:0]  page;
    logic        last_col;
    logic        last_page;
    logic [7:0]  map_x;
    logic [7:0]  map_y;
    logic [7:0]  tile_top;
    logic [7:0]  tile_bot;
    logic [7:0]  gfx_top;
    logic [7:0]  gfx_bot;
    logic [7:0]  gfx_tile;
    logic [23:0] tile_addr;
    logic [23:0] gfx_addr;
    logic [23:0] vram_addr;
    logic [7:0]  column_byte;

    assign map_x = {1'b0, col} + {1'b0, geom.scroll_x};
    assign map_y = {2'b00, page, 3'b000} + {1'b0, geom.scroll_y};

    assign last_col  = (col == 7'(SCREEN_COLUMNS - 1));
    assign last_page = (page == 3'(SCREEN_PAGES - 1));
    assign done      = active && !phase && (step == 3'd4) && last_col && last_page;

    assign tile_addr = TILE_MAP_BASE + 24'(map_y[7:3]) * 24'(geom.map_width) + 24'(map_x[7:3]);
    assign gfx_tile  = (step == 3'd2) ? tile_top : tile_bot;
    assign gfx_addr  = {3'b000, geom.map_base} + {13'd0, gfx_tile, map_x[2:0]};
    assign vram_addr = VRAM_BASE + 24'(page) * VRAM_PAGE_STRIDE + 24'(col);

    // Top tile supplies the upper rows, bottom tile fills in below it
    assign column_byte = (gfx_top >> map_y[2:0]) | (gfx_bot << (4'd8 - {1'b0, map_y[2:0]}));

    always_comb
    begin
        mem_req = '0;
        if (active && !phase)
        begin
            case (step)
                3'd0: begin mem_req.read = 1'b1; mem_req.addr = tile_addr; end
                3'd1:
                begin
                    mem_req.read = 1'b1;
                    mem_req.addr = tile_addr + 24'(geom.map_width);   // One map row down
                end
                3'd2, 3'd3: begin mem_req.read = 1'b1; mem_req.addr = gfx_addr; end
                default:
                begin
                    mem_req.write = 1'b1;
                    mem_req.addr  = vram_addr;
                    mem_req.wdata = invert ? ~column_byte : column_byte;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            phase  <= 1'b0;
            step   <= '0;
            col    <= '0;
            page   <= '0;
        end
        else if (start)
        begin
            active <= 1'b1;
            phase  <= 1'b0;
            step   <= '0;
            col    <= '0;
            page   <= '0;
        end
        else if (active)
        begin
            phase <= ~phase;
            if (done)
                active <= 1'b0;
            else if (phase && step == 3'd4)
            begin
                step <= '0;
                col  <= last_col ? 7'd0 : col + 7'd1;
                if (last_col)
                    page <= page + 3'd1;
            end
            else if (phase)
                step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (active && phase)
        begin
            case (step)
                3'd0:    tile_top <= mem_rd_data;
                3'd1:    tile_bot <= mem_rd_data;
                3'd2:    gfx_top  <= mem_rd_data;
                3'd3:    gfx_bot  <= mem_rd_data;
                default: ;
            endcase
        end
    end

    // Bus goes quiet once the last column is written
    assert property (@(posedge clk) disable iff (reset)
        done |=> !(mem_req.read || mem_req.write));

endmodule

//--- design/prc_frame_copier.sv
`timescale 1ns/1ps

module prc_frame_copier #(
    parameter int SCREEN_COLUMNS = 96,
    parameter int SCREEN_PAGES   = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [7:0]             mem_rd_data,
    output prc_bus_pkg::mem_req_t  mem_req,
    output logic                   done
);
    import prc_bus_pkg::*;

    typedef enum logic [2:0] {
        CP_COL_LOW,
        CP_COL_HIGH,
        CP_PAGE,
        CP_READ,
        CP_WRITE
    } copy_state_t;

    copy_state_t state;
    logic        active;
    logic        phase;
    logic [6:0]  col;
    logic [2:0]  page;
    logic        last_col;
    logic [7:0]  pixel_q;

    assign last_col = (col == 7'(SCREEN_COLUMNS - 1));
    assign done     = active && !phase && state == CP_WRITE && last_col
                      && (page == 3'(SCREEN_PAGES - 1));

    always_comb
    begin
        mem_req = '0;
        if (active && !phase)
        begin
            mem_req.write = (state != CP_READ);
            mem_req.read  = (state == CP_READ);
            case (state)
                CP_COL_LOW:  begin mem_req.addr = LCD_CMD_ADDR; mem_req.wdata = LCD_COL_LOW_CMD; end
                CP_COL_HIGH: begin mem_req.addr = LCD_CMD_ADDR; mem_req.wdata = LCD_COL_HIGH_CMD; end
                CP_PAGE:
                begin
                    mem_req.addr  = LCD_CMD_ADDR;
                    mem_req.wdata = LCD_PAGE_CMD | {5'd0, page};
                end
                CP_READ: mem_req.addr = VRAM_BASE + 24'(page) * VRAM_PAGE_STRIDE + 24'(col);
                default: begin mem_req.addr = LCD_DATA_ADDR; mem_req.wdata = pixel_q; end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            phase  <= 1'b0;
            state  <= CP_COL_LOW;
            col    <= '0;
            page   <= '0;
        end
        else if (start)
        begin
            active <= 1'b1;
            phase  <= 1'b0;
            state  <= CP_COL_LOW;
            col    <= '0;
            page   <= '0;
        end
        else if (active)
        begin
            phase <= ~phase;
            if (done)
                active <= 1'b0;
            else if (phase && state == CP_WRITE)
            begin
                col   <= last_col ? 7'd0 : col + 7'd1;
                state <= last_col ? CP_COL_LOW : CP_READ;   // New page needs the address commands
                if (last_col)
                    page <= page + 3'd1;
            end
            else if (phase)
                state <= copy_state_t'(state + 3'd1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (active && phase && state == CP_READ)
            pixel_q <= mem_rd_data;
    end

    assert property (@(posedge clk) disable iff (reset) active |-> !start);

endmodule

//--- design/prc_stage_sequencer.sv
`timescale 1ns/1ps

module prc_stage_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_start,
    input  prc_cfg_pkg::prc_mode_t  mode,
    input  prc_bus_pkg::mem_req_t   map_req,
    input  prc_bus_pkg::mem_req_t   copy_req,
    input  logic                    map_done,
    input  logic                    copy_done,
    output logic                    map_start,
    output logic                    copy_start,
    output prc_bus_pkg::mem_req_t   mem_req,
    output logic                    busy,
    output logic                    irq_render_done,
    output logic                    irq_copy_complete
);
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_MAP, SEQ_COPY} seq_state_t;

    seq_state_t state;
    logic       copy_en_q;   // Copy enable held for the whole run
    logic       accept;

    assign accept = frame_start && state == SEQ_IDLE && (mode.map_en || mode.copy_en);
    assign busy   = (state != SEQ_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state             <= SEQ_IDLE;
            copy_en_q         <= 1'b0;
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
            case (state)
                SEQ_IDLE:
                begin
                    if (accept)
                    begin
                        copy_en_q  <= mode.copy_en;
                        state      <= mode.map_en ? SEQ_MAP : SEQ_COPY;
                        map_start  <= mode.map_en;
                        copy_start <= !mode.map_en;
                    end
                end
                SEQ_MAP:
                begin
                    if (map_done)
                    begin
                        state           <= copy_en_q ? SEQ_COPY : SEQ_IDLE;
                        copy_start      <= copy_en_q;
                        irq_render_done <= !copy_en_q;
                    end
                end
                default:
                begin
                    if (copy_done)
                    begin
                        state             <= SEQ_IDLE;
                        irq_render_done   <= 1'b1;
                        irq_copy_complete <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb
    begin
        case (state)
            SEQ_MAP:  mem_req = map_req;
            SEQ_COPY: mem_req = copy_req;
            default:  mem_req = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) !(mem_req.read && mem_req.write));
    // A stage may only touch the bus while it owns it
    assert property (@(posedge clk) disable iff (reset)
        (state != SEQ_MAP) |-> !(map_req.read || map_req.write));
    assert property (@(posedge clk) disable iff (reset)
        (state != SEQ_COPY) |-> !(copy_req.read || copy_req.write));

endmodule

//--- design/prc_top.sv
`timescale 1ns/1ps

module prc_top #(
    parameter int SCREEN_COLUMNS = 96,
    parameter int SCREEN_PAGES   = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  prc_cfg_pkg::cpu_bus_t  cpu,
    input  logic [23:0]            reg_rd_addr,
    output logic [7:0]             reg_rd_data,
    input  logic                   frame_start,
    output prc_bus_pkg::mem_req_t  mem_req,
    input  logic [7:0]             mem_rd_data,
    output logic                   busy,
    output logic                   irq_render_done,
    output logic                   irq_copy_complete
);
    import prc_bus_pkg::*;
    import prc_cfg_pkg::*;

    prc_mode_t mode;
    map_geom_t geom;
    mem_req_t  map_req;
    mem_req_t  copy_req;
    logic      map_start;
    logic      copy_start;
    logic      map_done;
    logic      copy_done;

    prc_registers #(.SCREEN_COLUMNS(SCREEN_COLUMNS), .SCREEN_PAGES(SCREEN_PAGES)) u_registers (
        .clk, .reset, .cpu, .reg_rd_addr, .reg_rd_data, .mode, .geom
    );

    prc_stage_sequencer u_sequencer (
        .clk, .reset, .frame_start, .mode, .map_req, .copy_req, .map_done, .copy_done,
        .map_start, .copy_start, .mem_req, .busy, .irq_render_done, .irq_copy_complete
    );

    prc_map_renderer #(.SCREEN_COLUMNS(SCREEN_COLUMNS), .SCREEN_PAGES(SCREEN_PAGES)) u_renderer (
        .clk, .reset, .start(map_start), .geom, .invert(mode.invert), .mem_rd_data,
        .mem_req(map_req), .done(map_done)
    );

    prc_frame_copier #(.SCREEN_COLUMNS(SCREEN_COLUMNS), .SCREEN_PAGES(SCREEN_PAGES)) u_copier (
        .clk, .reset, .start(copy_start), .mem_rd_data, .mem_req(copy_req), .done(copy_done)
    );

endmodule

//--- tests/prc_tb.sv
`timescale 1ns/1ps

module prc_tb;
    import prc_bus_pkg::*;
    import prc_cfg_pkg::*;

    localparam int COLS           = 16;
    localparam int PAGES          = 2;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_ROWS       = 5;
    localparam int MAP_CYCLES     = 10 * COLS * PAGES;
    localparam int COPY_CYCLES    = (6 + 4 * COLS) * PAGES;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (MAP_CYCLES + COPY_CYCLES + 200);
    localparam int MAP_BYTES      = 384;    // Largest map, 24 x 16 tiles
    localparam int GFX_BYTES      = 2048;   // 256 tiles of 8 bytes

    // One stimulus row, written values first, then expected readback
    typedef struct packed {
        logic [7:0] mode;
        logic [7:0] base_lo;
        logic [7:0] base_mid;
        logic [7:0] base_hi;
        logic [7:0] scroll_x;
        logic [7:0] scroll_y;
        logic [7:0] rb_mode;
        logic [7:0] rb_base_lo;
        logic [7:0] rb_base_mid;
        logic [7:0] rb_base_hi;
        logic [7:0] rb_scroll_x;
        logic [7:0] rb_scroll_y;
    } stim_row_t;

    logic        clk;
    logic        reset;
    cpu_bus_t    cpu;
    logic [23:0] reg_rd_addr;
    logic [7:0]  reg_rd_data;
    logic        frame_start;
    mem_req_t    mem_req;
    logic [7:0]  mem_rd_data;
    logic        busy;
    logic        irq_render_done;
    logic        irq_copy_complete;

    logic [7:0]  mem [0:65535];
    logic [8:0]  lcd_log [$];       // Bit 8 set for data port writes
    logic [7:0]  vram_before [$];
    stim_row_t   rows [$];
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          render_irqs;
    int          copy_irqs;
    prc_mode_t   ref_mode;          // Model of the register file
    int          ref_width;
    int          ref_scroll_x;
    int          ref_scroll_y;
    int          ref_base;

    prc_top #(.SCREEN_COLUMNS(COLS), .SCREEN_PAGES(PAGES)) DUT (
        .clk, .reset, .cpu, .reg_rd_addr, .reg_rd_data, .frame_start, .mem_req, .mem_rd_data,
        .busy, .irq_render_done, .irq_copy_complete
    );

    always #20 clk = ~clk;

    // Memory model, read data one cycle after the strobe
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
        if (mem_req.read)
            mem_rd_data <= mem[mem_req.addr[15:0]];
        if (mem_req.write)
        begin
            mem[mem_req.addr[15:0]] = mem_req.wdata;
            if (mem_req.addr == LCD_CMD_ADDR || mem_req.addr == LCD_DATA_ADDR)
                lcd_log.push_back({mem_req.addr == LCD_DATA_ADDR, mem_req.wdata});
        end
    end

    always @(negedge clk)
    begin
        if (!reset && irq_render_done)
        begin
            render_irqs++;
            check_count("busy", int'(busy), 0);    // Falls with the interrupt
        end
        if (!reset && irq_copy_complete)
            copy_irqs++;
    end

    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] expected);
        assert (got === expected)
        else
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected)
        else
        begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
            report_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] mem_byte(input int addr);
        return mem[addr[15:0]];
    endfunction

    task automatic write_reg(input logic [23:0] addr, input logic [7:0] data);
        cpu.write = 1'b1;
        cpu.addr  = addr;
        cpu.wdata = data;
        next_cycle();
        cpu.write = 1'b0;
    endtask

    task automatic check_readback(input logic [23:0] addr, input logic [7:0] expected);
        reg_rd_addr = addr;
        #1;
        check_byte($sformatf("reg_rd_data[%h]", addr), reg_rd_data, expected);
    endtask

    task automatic apply_registers(input stim_row_t r);
        int height;
        write_reg(REG_MODE, r.mode);
        write_reg(REG_MAP_BASE_LO, r.base_lo);
        write_reg(REG_MAP_BASE_MID, r.base_mid);
        write_reg(REG_MAP_BASE_HI, r.base_hi);
        write_reg(REG_SCROLL_Y, r.scroll_y);
        write_reg(REG_SCROLL_X, r.scroll_x);
        ref_mode  = prc_mode_t'(r.mode[5:0]);
        ref_width = (ref_mode.map_size == 2'd0) ? 12 : (ref_mode.map_size == 2'd1) ? 16 : 24;
        height    = (ref_mode.map_size == 2'd2) ? 8 : (ref_mode.map_size == 2'd1) ? 12 : 16;
        if (int'(r.scroll_x[6:0]) <= 8 * ref_width - COLS)
            ref_scroll_x = int'(r.scroll_x[6:0]);     // Else the old value stays
        if (int'(r.scroll_y[6:0]) <= 8 * height - 8 * PAGES)
            ref_scroll_y = int'(r.scroll_y[6:0]);
        ref_base = int'({r.base_hi[4:0], r.base_mid, r.base_lo[7:3], 3'b000});
        check_readback(REG_MODE, r.rb_mode);
        check_readback(REG_MAP_BASE_LO, r.rb_base_lo);
        check_readback(REG_MAP_BASE_MID, r.rb_base_mid);
        check_readback(REG_MAP_BASE_HI, r.rb_base_hi);
        check_readback(REG_SCROLL_Y, r.rb_scroll_y);
        check_readback(REG_SCROLL_X, r.rb_scroll_x);
        check_readback(24'h002081, 8'h00);
        check_readback(24'h002087, 8'h00);
        check_readback(24'h00208A, 8'h00);
    endtask

    task automatic fill_tiles_and_graphics();
        logic [7:0] b;
        int         addr;
        for (int a = 0; a < MAP_BYTES; a++)
        begin
            random_byte(b);
            addr = int'(TILE_MAP_BASE) + a;
            mem[addr[15:0]] = b;
        end
        for (int a = 0; a < GFX_BYTES; a++)
        begin
            random_byte(b);
            addr = ref_base + a;        // Upper base bits alias in the 64 KB model
            mem[addr[15:0]] = b;
        end
    endtask

    task automatic check_vram();
        int         mx;
        int         my;
        int         tile_addr;
        int         shift;
        int         addr;
        logic [7:0] gfx_top;
        logic [7:0] gfx_bot;
        logic [7:0] expected;
        for (int p = 0; p < PAGES; p++)
        begin
            for (int c = 0; c < 96; c++)
            begin
                addr     = int'(VRAM_BASE) + 96 * p + c;
                expected = vram_before[96 * p + c];
                if (ref_mode.map_en && c < COLS)
                begin
                    mx        = c + ref_scroll_x;
                    my        = 8 * p + ref_scroll_y;
                    tile_addr = int'(TILE_MAP_BASE) + (my / 8) * ref_width + mx / 8;
                    gfx_top   = mem_byte(ref_base + 8 * int'(mem_byte(tile_addr)) + mx % 8);
                    gfx_bot   = mem_byte(ref_base + 8 * int'(mem_byte(tile_addr + ref_width))
                                         + mx % 8);
                    shift     = my % 8;
                    expected  = (gfx_top >> shift) | (gfx_bot << (8 - shift));
                    if (ref_mode.invert)
                        expected = ~expected;
                end
                check_byte($sformatf("vram[%h]", addr), mem_byte(addr), expected);
            end
        end
    endtask

    task automatic check_lcd_log();
        logic [8:0] expected [$];
        for (int p = 0; p < PAGES && ref_mode.copy_en; p++)
        begin
            expected.push_back({1'b0, LCD_COL_LOW_CMD});
            expected.push_back({1'b0, LCD_COL_HIGH_CMD});
            expected.push_back({1'b0, LCD_PAGE_CMD | 8'(p)});
            for (int c = 0; c < COLS; c++)
                expected.push_back({1'b1, mem_byte(int'(VRAM_BASE) + 96 * p + c)});
        end
        check_count("lcd_log size", lcd_log.size(), expected.size());
        foreach (expected[i])
            check_count($sformatf("lcd_log[%0d]", i), int'(lcd_log[i]), int'(expected[i]));
    endtask

    initial
    begin
        int render_before;
        int copy_before;
        clk          = 1'b0;
        reset        = 1'b1;
        cpu          = '0;
        reg_rd_addr  = '0;
        frame_start  = 1'b0;
        mem_rd_data  = '0;
        lfsr_state   = 32'h1029;
        cycle_count  = 0;
        render_irqs  = 0;
        copy_irqs    = 0;
        ref_mode     = '0;
        ref_width    = 12;
        ref_scroll_x = 0;
        ref_scroll_y = 0;
        ref_base     = 0;
        for (int a = 0; a < 65536; a++)
            mem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'hA5;

        // mode, lo, mid, hi, sx, sy, then the expected readback in the same order
        rows.push_back({8'h0A, 8'h07, 8'h40, 8'h00, 8'h05, 8'h03,
                        8'h0A, 8'h00, 8'h40, 8'h00, 8'h05, 8'h03});
        rows.push_back({8'h1B, 8'h3F, 8'h8A, 8'hE0, 8'h70, 8'h55,
                        8'h1B, 8'h38, 8'h8A, 8'h00, 8'h70, 8'h55});
        rows.push_back({8'h22, 8'hFF, 8'h30, 8'hE1, 8'hC5, 8'h30,
                        8'h22, 8'hF8, 8'h30, 8'h01, 8'h45, 8'h30});   // Map only
        rows.push_back({8'h3C, 8'h00, 8'h50, 8'h00, 8'h28, 8'h7F,
                        8'h3C, 8'h00, 8'h50, 8'h00, 8'h28, 8'h7F});   // Copy only
        rows.push_back({8'hCB, 8'h08, 8'h60, 8'h1F, 8'h51, 8'h70,
                        8'h0B, 8'h08, 8'h60, 8'h1F, 8'h51, 8'h70});

        repeat (3) next_cycle();
        reset = 1'b0;
        @(negedge clk);
        check_count("busy", int'(busy), 0);
        check_count("irq_render_done", int'(irq_render_done), 0);
        check_count("irq_copy_complete", int'(irq_copy_complete), 0);
        check_count("mem_req strobes", int'({mem_req.read, mem_req.write}), 0);

        // No stage enabled, so the strobe is dropped
        next_cycle();
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        @(negedge clk);
        check_count("busy", int'(busy), 0);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            apply_registers(rows[i]);
            fill_tiles_and_graphics();
            vram_before.delete();
            for (int a = 0; a < 96 * PAGES; a++)
                vram_before.push_back(mem_byte(int'(VRAM_BASE) + a));
            lcd_log.delete();
            render_before = render_irqs;
            copy_before   = copy_irqs;
            frame_start = 1'b1;
            next_cycle();
            frame_start = 1'b0;
            @(negedge clk);
            check_count("busy", int'(busy), 1);
            next_cycle();
            frame_start = 1'b1;     // Lands while busy
            next_cycle();
            frame_start = 1'b0;
            while (render_irqs == render_before)
                @(posedge clk);
            repeat (4) @(negedge clk);
            check_count("irq_render_done pulses", render_irqs - render_before, 1);
            check_count("irq_copy_complete pulses", copy_irqs - copy_before,
                        int'(ref_mode.copy_en));
            check_count("busy", int'(busy), 0);
            check_vram();
            check_lcd_log();
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- files.f
design/prc_bus_pkg.sv
design/prc_cfg_pkg.sv
design/prc_registers.sv
design/prc_map_renderer.sv
design/prc_frame_copier.sv
design/prc_stage_sequencer.sv
design/prc_top.sv
tests/prc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= prc_tb
FLAGS     ?= --assert
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
